//--- src/mmio_pkg.sv
// MMIO bus definitions shared by the register test block.
// Holds the widths of the narrow and wide ports, their request and response
// structs, the per-lane structs of the wide write path and the byte offset rule.

`default_nettype none

package mmio_pkg;

    // Number of 64-bit lanes in one 512-bit wide word
    localparam int num_lanes = 8;

    typedef logic [63:0]  mmio_word_t;
    typedef logic [511:0] mmio_data512_t;

    // Addresses are word indices, not byte addresses
    typedef logic [11:0] mmio_addr64_t;
    typedef logic [8:0]  mmio_addr512_t;

    typedef logic [7:0]  mmio_mask64_t;
    typedef logic [63:0] mmio_mask512_t;

    // Byte offset of the first enabled byte within a word
    typedef logic [2:0] mmio_bidx64_t;
    typedef logic [5:0] mmio_bidx512_t;

    typedef struct packed {
        logic         read;
        logic         write;
        mmio_addr64_t address;
        mmio_mask64_t byteenable;
        mmio_word_t   writedata;
    } mmio64_req_t;

    // The wide port is write only, so it carries no read strobe
    typedef struct packed {
        logic          write;
        mmio_addr512_t address;
        mmio_mask512_t byteenable;
        mmio_data512_t writedata;
    } mmio512_req_t;

    typedef struct packed {
        logic       readdatavalid;
        mmio_word_t readdata;
    } mmio64_rsp_t;

    // One lane write, strobed the cycle after a wide write is accepted
    typedef struct packed {
        logic         strobe;
        mmio_word_t   data;
        mmio_mask64_t mask;
    } lane_wr_t;

    typedef struct packed {
        mmio_word_t   data;
        mmio_mask64_t mask;
    } lane_state_t;

    // Index of the lowest set bit in a byte enable mask
    // An empty mask maps to offset 0, and narrow masks are zero extended first
    function automatic mmio_bidx512_t mask_to_bidx(mmio_mask512_t mask);
        mmio_bidx512_t idx;
        idx = '0;
        // Scan downward so that the last hit is the lowest enabled byte
        for (int i = 63; i >= 0; i--)
        begin
            if (mask[i])
            begin
                idx = mmio_bidx512_t'(i);
            end
        end
        return idx;
    endfunction

endpackage

`default_nettype wire

//--- src/csr_pkg.sv
// Register map of the MMIO test block.
// Holds the 64-bit register indices, the device feature header, the
// accelerator ID and the constant status word.

`default_nettype none

package csr_pkg;

    // Index of a 64-bit register in the narrow port address space
    typedef logic [11:0] csr_idx_t;

    // ========================================================================
    // Register indices
    // ========================================================================

    // Feature header group, reduced in the first read stage
    localparam csr_idx_t csr_dfh      = 12'h000;
    localparam csr_idx_t csr_id_lo    = 12'h001;
    localparam csr_idx_t csr_id_hi    = 12'h002;
    localparam csr_idx_t csr_req_addr = 12'h007;

    localparam csr_idx_t csr_status = 12'h010;

    // State of the last narrow write
    localparam csr_idx_t csr_wr64_data = 12'h020;
    localparam csr_idx_t csr_wr64_addr = 12'h030;
    localparam csr_idx_t csr_wr64_mask = 12'h031;

    // State of the last wide write, lane i of the data sits at base plus i
    localparam csr_idx_t csr_wr512_data_base = 12'h040;
    localparam csr_idx_t csr_wr512_addr      = 12'h050;
    localparam csr_idx_t csr_wr512_mask      = 12'h051;

    // ========================================================================
    // Constant register contents
    // ========================================================================

    localparam logic [127:0] accel_id = 128'h5f1c_3d2a_8e47_4b09_a6c3_71e2_90d4_b815;

    // A one entry feature list of type accelerator, flagged as end of list
    localparam mmio_pkg::mmio_word_t dfh_value = {4'h1, 19'h0, 1'b1, 40'h0};

    localparam logic [15:0] clk_freq_mhz = 16'd200;

    // Interface type 0 stands for the Avalon style MMIO ports
    localparam logic [3:0] iface_type_avalon = 4'h0;

    localparam mmio_pkg::mmio_word_t status_value =
        {32'h0, clk_freq_mhz, 12'h0, iface_type_avalon};

endpackage

`default_nettype wire

//--- src/mmio_wait_gen.sv
// Waitrequest pattern generator for both MMIO ports.
// A rotating 16-bit ring stalls each port for fifteen cycles out of sixteen.

`timescale 1ns/1ps
`default_nettype none

module mmio_wait_gen
(
    input  wire  clk,
    input  wire  reset_n,
    output logic wait64,
    output logic wait512
);

    // A single zero circulates through the ring and marks the ready cycle
    logic [15:0] wait_ring;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wait_ring <= {~15'b0, 1'b0};
        end
        else
        begin
            wait_ring <= {wait_ring[14:0], wait_ring[15]};
        end
    end

    // The two taps sit half a turn apart so the ports are ready at different times
    assign wait64  = wait_ring[0];
    assign wait512 = wait_ring[8];

endmodule

`default_nettype wire

//--- src/mmio_lane_capture.sv
// Capture register for one 64-bit lane of the wide write port.
// Keeps the data word and byte mask of the most recent lane write.

`timescale 1ns/1ps
`default_nettype none

module mmio_lane_capture
(
    input  wire                   clk,
    input  wire                   reset_n,
    input  mmio_pkg::lane_wr_t    lane_wr,
    output mmio_pkg::lane_state_t lane_state
);

    import mmio_pkg::*;

    // Reset fills data and mask with ones, which marks a lane never written
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            lane_state <= '1;
        end
        else if (lane_wr.strobe)
        begin
            lane_state.data <= lane_wr.data;
            lane_state.mask <= lane_wr.mask;
        end
    end

    // The wide port clears its strobe on reset, so a strobe right after a
    // reset edge means the two blocks disagree about reset
    a_no_strobe_in_reset: assert property (@(posedge clk)
        $past(!reset_n) |-> !lane_wr.strobe);

endmodule

`default_nettype wire

//--- src/mmio_wide_write_port.sv
// Write side of the 512-bit MMIO port.
// Records address and byte offset of each accepted write and hands the
// data and mask on to the eight lane capture blocks as strobed lane writes.

`timescale 1ns/1ps
`default_nettype none

module mmio_wide_write_port
(
    input  wire                    clk,
    input  wire                    reset_n,
    input  mmio_pkg::mmio512_req_t req512,
    input  wire                    wait512,
    output mmio_pkg::lane_wr_t [mmio_pkg::num_lanes-1:0] lane_wr,
    output mmio_pkg::mmio_addr512_t wr_addr,
    output mmio_pkg::mmio_bidx512_t wr_bidx
);

    import mmio_pkg::*;

    logic          wr_accept;
    logic          strobe_q;
    mmio_data512_t data_q;
    mmio_mask512_t mask_q;

    // A write is taken on an edge where the slave is not stalling it
    assign wr_accept = req512.write && !wait512;

    // ========================================================================
    // Address and byte offset record
    // ========================================================================

    // Reset leaves the record at all ones so an unwritten port is easy to spot
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_addr <= '1;
            wr_bidx <= '1;
        end
        else if (wr_accept)
        begin
            wr_addr <= req512.address;
            wr_bidx <= mask_to_bidx(req512.byteenable);
        end
    end

    // ========================================================================
    // Lane write staging
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            strobe_q <= 1'b0;
        end
        else
        begin
            strobe_q <= wr_accept;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_accept)
        begin
            data_q <= req512.writedata;
            mask_q <= req512.byteenable;
        end
    end

    // Lane i takes data bits 64i+63:64i and mask bits 8i+7:8i
    always_comb
    begin
        for (int i = 0; i < num_lanes; i++)
        begin
            lane_wr[i].strobe = strobe_q;
            lane_wr[i].data   = data_q[i*64 +: 64];
            lane_wr[i].mask   = mask_q[i*8 +: 8];
        end
    end

    // An undefined address would corrupt the record at 0x50
    a_wr_addr_known: assert property (@(posedge clk) disable iff (!reset_n)
        req512.write |-> !$isunknown(req512.address));

endmodule

`default_nettype wire

//--- src/mmio_narrow_write_port.sv
// Write side of the 64-bit MMIO port.
// Records data, word address, byte mask and first byte offset of every
// accepted narrow write for readback through the register map.

`timescale 1ns/1ps
`default_nettype none

module mmio_narrow_write_port
(
    input  wire                   clk,
    input  wire                   reset_n,
    input  mmio_pkg::mmio64_req_t req64,
    input  wire                   wait64,
    output mmio_pkg::mmio_word_t  wr_data,
    output mmio_pkg::mmio_addr64_t wr_addr,
    output mmio_pkg::mmio_mask64_t wr_mask,
    output mmio_pkg::mmio_bidx64_t wr_bidx
);

    import mmio_pkg::*;

    logic wr_accept;

    assign wr_accept = req64.write && !wait64;

    // The record is visible to a read accepted on any later edge
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_data <= '0;
            wr_addr <= '0;
            wr_mask <= '0;
            wr_bidx <= '0;
        end
        else if (wr_accept)
        begin
            wr_data <= req64.writedata;
            wr_addr <= req64.address;
            wr_mask <= req64.byteenable;
            // Same lowest byte rule as the wide port, on a zero extended mask
            wr_bidx <= mmio_bidx64_t'(mask_to_bidx(mmio_mask512_t'(req64.byteenable)));
        end
    end

    // The read pipeline and this port share one request, so both at once is illegal
    a_no_read_and_write: assert property (@(posedge clk) disable iff (!reset_n)
        !(req64.read && req64.write));

endmodule

`default_nettype wire

//--- src/mmio_read_unit.sv
// Read pipeline of the 64-bit MMIO port.
// Stage 1 takes the read and reduces the header group and the wide lanes,
// stage 2 selects by register index. Data returns two cycles after acceptance.

`timescale 1ns/1ps
`default_nettype none

module mmio_read_unit
(
    input  wire                     clk,
    input  wire                     reset_n,
    input  mmio_pkg::mmio64_req_t   req64,
    input  wire                     wait64,
    input  mmio_pkg::mmio_word_t    narrow_data,
    input  mmio_pkg::mmio_addr64_t  narrow_addr,
    input  mmio_pkg::mmio_mask64_t  narrow_mask,
    input  mmio_pkg::mmio_bidx64_t  narrow_bidx,
    input  mmio_pkg::mmio_addr512_t wide_addr,
    input  mmio_pkg::mmio_bidx512_t wide_bidx,
    input  mmio_pkg::lane_state_t [mmio_pkg::num_lanes-1:0] lanes,
    output mmio_pkg::mmio64_rsp_t   rsp64
);

    import mmio_pkg::*;
    import csr_pkg::*;

    logic          rd_accept;
    csr_idx_t      rd_idx;
    mmio_bidx64_t  req_bidx;
    logic [31:0]   req_byte_addr;
    logic          rd_valid_q;
    csr_idx_t      rd_idx_q;
    mmio_word_t    hdr_q;
    mmio_word_t    lane_q;
    mmio_mask512_t wide_mask;
    mmio_word_t    rd_mux;
    logic          rdv_q;
    mmio_word_t    rdata_q;

    assign rd_accept = req64.read && !wait64;
    assign rd_idx    = csr_idx_t'(req64.address);

    // Byte address of the current request, word index times eight plus offset
    assign req_bidx      = mmio_bidx64_t'(mask_to_bidx(mmio_mask512_t'(req64.byteenable)));
    assign req_byte_addr = 32'({req64.address, req_bidx});

    // ========================================================================
    // Stage 1
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rd_valid_q <= 1'b0;
        end
        else
        begin
            rd_valid_q <= rd_accept;
        end
    end

    // The reductions run every cycle, only the valid bit marks a real read
    always_ff @(posedge clk)
    begin
        rd_idx_q <= rd_idx;
        lane_q   <= lanes[rd_idx[2:0]].data;

        case (rd_idx[3:0])
            csr_dfh[3:0]:      hdr_q <= dfh_value;
            csr_id_lo[3:0]:    hdr_q <= accel_id[63:0];
            csr_id_hi[3:0]:    hdr_q <= accel_id[127:64];
            // Replicated so either 32-bit half reads the full byte address
            csr_req_addr[3:0]: hdr_q <= {req_byte_addr, req_byte_addr};
            default:           hdr_q <= '0;
        endcase
    end

    // ========================================================================
    // Stage 2
    // ========================================================================

    // The wide mask is spread across the lanes, lane 0 in the low byte
    always_comb
    begin
        for (int i = 0; i < num_lanes; i++)
        begin
            wide_mask[i*8 +: 8] = lanes[i].mask;
        end
    end

    always_comb
    begin
        if (rd_idx_q[11:4] == csr_dfh[11:4])
        begin
            rd_mux = hdr_q;
        end
        else if (rd_idx_q[11:3] == csr_wr512_data_base[11:3])
        begin
            rd_mux = lane_q;
        end
        else
        begin
            case (rd_idx_q)
                csr_status:     rd_mux = status_value;
                csr_wr64_data:  rd_mux = narrow_data;
                csr_wr64_addr:  rd_mux = mmio_word_t'({narrow_addr, narrow_bidx});
                csr_wr64_mask:  rd_mux = mmio_word_t'(narrow_mask);
                csr_wr512_addr: rd_mux = mmio_word_t'({wide_addr, wide_bidx});
                csr_wr512_mask: rd_mux = wide_mask;
                // Unmapped indices read as zero
                default:        rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rdv_q <= 1'b0;
        end
        else
        begin
            rdv_q <= rd_valid_q;
        end
    end

    always_ff @(posedge clk)
    begin
        rdata_q <= rd_mux;
    end

    assign rsp64.readdatavalid = rdv_q;
    assign rsp64.readdata      = rdata_q;

    // Fixed latency of two cycles from the accepting edge, with no slip
    a_read_latency: assert property (@(posedge clk) disable iff (!reset_n)
        $past(reset_n) |-> (rsp64.readdatavalid == $past(rd_accept && reset_n, 2)));

endmodule

`default_nettype wire

//--- src/mmio_test_top.sv
// Top of the MMIO register test block.
// Ties the waitrequest generator, the narrow and wide write ports, the
// eight lane capture registers and the read pipeline together.

`timescale 1ns/1ps
`default_nettype none

module mmio_test_top
(
    input  wire                    clk,
    input  wire                    reset_n,
    input  mmio_pkg::mmio64_req_t  req64,
    output logic                   wait64,
    output mmio_pkg::mmio64_rsp_t  rsp64,
    input  mmio_pkg::mmio512_req_t req512,
    output logic                   wait512
);

    import mmio_pkg::*;

    lane_wr_t    [num_lanes-1:0] lane_wr;
    lane_state_t [num_lanes-1:0] lane_state;

    mmio_word_t    narrow_data;
    mmio_addr64_t  narrow_addr;
    mmio_mask64_t  narrow_mask;
    mmio_bidx64_t  narrow_bidx;
    mmio_addr512_t wide_addr;
    mmio_bidx512_t wide_bidx;

    mmio_wait_gen u_wait_gen
    (
        .clk     (clk),
        .reset_n (reset_n),
        .wait64  (wait64),
        .wait512 (wait512)
    );

    mmio_wide_write_port u_wide_write
    (
        .clk     (clk),
        .reset_n (reset_n),
        .req512  (req512),
        .wait512 (wait512),
        .lane_wr (lane_wr),
        .wr_addr (wide_addr),
        .wr_bidx (wide_bidx)
    );

    // One capture register per 64-bit lane of the wide word
    for (genvar i = 0; i < num_lanes; i++)
    begin : g_lane
        mmio_lane_capture u_lane
        (
            .clk        (clk),
            .reset_n    (reset_n),
            .lane_wr    (lane_wr[i]),
            .lane_state (lane_state[i])
        );
    end

    mmio_narrow_write_port u_narrow_write
    (
        .clk     (clk),
        .reset_n (reset_n),
        .req64   (req64),
        .wait64  (wait64),
        .wr_data (narrow_data),
        .wr_addr (narrow_addr),
        .wr_mask (narrow_mask),
        .wr_bidx (narrow_bidx)
    );

    mmio_read_unit u_read_unit
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .req64       (req64),
        .wait64      (wait64),
        .narrow_data (narrow_data),
        .narrow_addr (narrow_addr),
        .narrow_mask (narrow_mask),
        .narrow_bidx (narrow_bidx),
        .wide_addr   (wide_addr),
        .wide_bidx   (wide_bidx),
        .lanes       (lane_state),
        .rsp64       (rsp64)
    );

endmodule

`default_nettype wire

//--- sim/mmio_test_tb.sv
// Testbench of the MMIO register test block.
// Applies a table of narrow writes, wide writes and reads to both ports,
// checks every read response and watches the fixed read latency.

`timescale 1ns/1ps
`default_nettype none

module mmio_test_tb;

    import mmio_pkg::*;
    import csr_pkg::*;

    typedef enum logic [1:0] {op_wr64, op_wr512, op_rd, op_rd_nowait} op_t;

    // One table entry, the test name sits in a parallel string table
    typedef struct packed {
        op_t          op;
        logic [11:0]  addr;
        logic [63:0]  mask;
        logic [511:0] data;
        logic [63:0]  expected;
    } entry_t;

    logic         clk;
    logic         reset_n;
    mmio64_req_t  req64;
    mmio512_req_t req512;
    logic         wait64;
    logic         wait512;
    mmio64_rsp_t  rsp64;

    entry_t      test_tab[$];
    string       test_names[$];
    logic [63:0] pend_exp[$];
    string       pend_name[$];
    logic [63:0] rsp_q[$];

    integer seed = 92865;
    int     mismatch_count = 0;
    int     protocol_count = 0;
    int     cycle_count = 0;
    int     cycle_limit = 1000000;
    logic [1:0] accept_hist;
    logic [3:0] wait_phase;

    mmio_test_top dut
    (
        .clk     (clk),
        .reset_n (reset_n),
        .req64   (req64),
        .wait64  (wait64),
        .rsp64   (rsp64),
        .req512  (req512),
        .wait512 (wait512)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================================================
    // Checking and monitoring
    // ========================================================================

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            mismatch_count++;
        end
    endtask

    // Lowest enabled byte, counted up from byte 0; an empty mask gives 0
    function automatic int first_byte(input logic [63:0] mask);
        int pos;
        pos = 0;
        while (pos < 64 && !mask[pos])
        begin
            pos++;
        end
        if (pos == 64)
        begin
            pos = 0;
        end
        return pos;
    endfunction

    // Sampled at the falling edge, where inputs and DUT outputs are settled.
    // A read seen here as accepted shows its valid two falling edges later
    always @(negedge clk)
    begin
        if (!reset_n)
        begin
            accept_hist <= 2'b00;
            wait_phase  <= 4'd0;
        end
        else
        begin
            // The narrow port is ready in the first cycle after reset,
            // the wide port half a turn of sixteen cycles later
            check_value("wait64", 64'(wait_phase != 4'd0), 64'(wait64));
            check_value("wait512", 64'(wait_phase != 4'd8), 64'(wait512));
            wait_phase <= wait_phase + 4'd1;
            if (rsp64.readdatavalid !== accept_hist[1])
            begin
                $display("Error: readdatavalid at %0t does not come 2 cycles after an accepted read",
                         $time);
                protocol_count++;
            end
            if (rsp64.readdatavalid === 1'b1)
            begin
                rsp_q.push_back(rsp64.readdata);
            end
            accept_hist <= {accept_hist[0], req64.read && !wait64};
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Errors: %0d mismatches, %0d protocol errors",
                     mismatch_count, protocol_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // ========================================================================
    // Bus master tasks
    // ========================================================================

    // Each request is held until the falling edge shows the port ready,
    // so the next rising edge accepts it
    task automatic narrow_write(input logic [11:0] addr, input logic [7:0] mask,
                                input logic [63:0] data);
        @(posedge clk);
        #1;
        req64.write      = 1'b1;
        req64.address    = addr;
        req64.byteenable = mask;
        req64.writedata  = data;
        @(negedge clk);
        while (wait64)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req64 = '0;
    endtask

    task automatic narrow_read(input logic [11:0] addr, input logic [7:0] mask);
        @(posedge clk);
        #1;
        req64.read       = 1'b1;
        req64.address    = addr;
        req64.byteenable = mask;
        @(negedge clk);
        while (wait64)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req64 = '0;
    endtask

    task automatic wide_write(input logic [8:0] addr, input logic [63:0] mask,
                              input logic [511:0] data);
        @(posedge clk);
        #1;
        req512.write      = 1'b1;
        req512.address    = addr;
        req512.byteenable = mask;
        req512.writedata  = data;
        @(negedge clk);
        while (wait512)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req512 = '0;
    endtask

    // Responses come back in issue order, so they pair with the pending list
    task automatic drain_responses();
        while (pend_exp.size() > 0)
        begin
            while (rsp_q.size() == 0)
            begin
                @(posedge clk);
            end
            check_value(pend_name.pop_front(), pend_exp.pop_front(), rsp_q.pop_front());
        end
    endtask

    // ========================================================================
    // Test table construction
    // ========================================================================

    task automatic add_entry(input op_t op, input logic [11:0] addr, input logic [63:0] mask,
                             input logic [511:0] data, input logic [63:0] expected,
                             input string name);
        test_tab.push_back('{op: op, addr: addr, mask: mask, data: data, expected: expected});
        test_names.push_back(name);
    endtask

    task automatic add_read(input logic [11:0] addr, input logic [63:0] expected,
                            input string name);
        add_entry(op_rd, addr, 64'hff, '0, expected, name);
    endtask

    // A narrow write is read back as data, byte address and mask
    task automatic narrow_case(input logic [11:0] addr, input logic [7:0] mask,
                               input logic [63:0] data, input string name);
        add_entry(op_wr64, addr, 64'(mask), 512'(data), '0, name);
        add_read(csr_wr64_data, data, {name, "_data"});
        add_read(csr_wr64_addr, (64'(addr) << 3) + 64'(first_byte(64'(mask))),
                 {name, "_addr"});
        add_read(csr_wr64_mask, 64'(mask), {name, "_mask"});
    endtask

    // A wide write is read back lane by lane, then as byte address and mask
    task automatic wide_case(input logic [8:0] addr, input logic [63:0] mask,
                             input string name);
        logic [511:0] data;
        for (int i = 0; i < 16; i++)
        begin
            data[i*32 +: 32] = $random(seed);
        end
        add_entry(op_wr512, 12'(addr), mask, data, '0, name);
        for (int i = 0; i < num_lanes; i++)
        begin
            add_read(csr_wr512_data_base + 12'(i), data[i*64 +: 64],
                     $sformatf("%s_lane%0d", name, i));
        end
        add_read(csr_wr512_addr, (64'(addr) << 6) + 64'(first_byte(mask)), {name, "_addr"});
        add_read(csr_wr512_mask, mask, {name, "_mask"});
    endtask

    task automatic build_table();
        // Feature type 1 at the top nibble, end of list at bit 40
        add_read(csr_dfh, (64'h1 << 60) | (64'h1 << 40), "dfh");
        add_read(csr_id_lo, accel_id[63:0], "id_lo");
        add_read(csr_id_hi, accel_id[127:64], "id_hi");
        add_read(csr_status, {32'h0, clk_freq_mhz, 16'h0}, "status");
        // Reset contents, narrow record at zero, wide record at all ones
        add_read(csr_wr64_data, '0, "rst_wr64_data");
        add_read(csr_wr64_addr, '0, "rst_wr64_addr");
        add_read(csr_wr64_mask, '0, "rst_wr64_mask");
        for (int i = 0; i < num_lanes; i++)
        begin
            add_read(csr_wr512_data_base + 12'(i), '1, $sformatf("rst_lane%0d", i));
        end
        add_read(csr_wr512_addr, 64'h7fff, "rst_wr512_addr");
        add_read(csr_wr512_mask, '1, "rst_wr512_mask");
        narrow_case(12'h123, 8'hff, 64'h0123_4567_89ab_cdef, "wr64_full");
        narrow_case(12'h0ab, 8'h0c, 64'hdead_beef_0bad_f00d, "wr64_mid");
        narrow_case(12'hfff, 8'h80, 64'h8000_0000_0000_0001, "wr64_top");
        narrow_case(12'h005, 8'h00, 64'h5a5a_a5a5_3c3c_c3c3, "wr64_empty");
        wide_case(9'h1a5, '1, "wr512_full");
        wide_case(9'h033, 64'h0000_00f0_0000_0000, "wr512_part");
        // Request byte address echo, word 7 plus the offset of the read mask
        add_entry(op_rd, csr_req_addr, 64'h10, '0, {2{32'h3c}}, "req_addr_off4");
        add_read(csr_req_addr, {2{32'h38}}, "req_addr_off0");
        add_read(12'h011, '0, "unmapped_011");
        add_read(12'h060, '0, "unmapped_060");
        add_read(12'h003, '0, "unmapped_003");
        add_read(12'h048, '0, "unmapped_048");
        // Reads issued without waiting, checked in order by the last one
        add_entry(op_rd_nowait, csr_id_hi, 64'hff, '0, accel_id[127:64], "b2b_id_hi");
        add_entry(op_rd_nowait, csr_status, 64'hff, '0, {32'h0, clk_freq_mhz, 16'h0},
                  "b2b_status");
        add_read(csr_id_lo, accel_id[63:0], "b2b_id_lo");
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial
    begin
        entry_t ent;
        reset_n = 1'b0;
        req64   = '0;
        req512  = '0;
        build_table();
        cycle_limit = 64 * test_tab.size() + 200;

        repeat (2) @(posedge clk);
        #1;
        reset_n = 1'b1;

        for (int i = 0; i < test_tab.size(); i++)
        begin
            ent = test_tab[i];
            case (ent.op)
                op_wr64:
                begin
                    narrow_write(ent.addr, ent.mask[7:0], ent.data[63:0]);
                    repeat (4) @(posedge clk);
                end
                op_wr512:
                begin
                    // Lane state lands a cycle after the record, well inside the gap
                    wide_write(ent.addr[8:0], ent.mask, ent.data);
                    repeat (4) @(posedge clk);
                end
                default:
                begin
                    narrow_read(ent.addr, ent.mask[7:0]);
                    pend_exp.push_back(ent.expected);
                    pend_name.push_back(test_names[i]);
                    if (ent.op == op_rd)
                    begin
                        drain_responses();
                    end
                end
            endcase
        end
        drain_responses();

        // Any response left over here had no read behind it
        repeat (8) @(posedge clk);
        if (rsp_q.size() != 0)
        begin
            $display("Error: %0d read responses arrived without a matching read", rsp_q.size());
            protocol_count++;
        end

        $display("Errors: %0d mismatches, %0d protocol errors", mismatch_count, protocol_count);
        if (mismatch_count == 0 && protocol_count == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
src/mmio_pkg.sv
src/csr_pkg.sv
src/mmio_wait_gen.sv
src/mmio_lane_capture.sv
src/mmio_wide_write_port.sv
src/mmio_narrow_write_port.sv
src/mmio_read_unit.sv
src/mmio_test_top.sv
sim/mmio_test_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the MMIO test block with Verilator and runs its testbench.
# The run fails when the build fails, the simulator exits with an error,
# or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=mmio_test_sim

verilator --binary --timing --assert -f src.f --top-module mmio_test_tb \
    --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
